//--- src/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register file size (x0..x31)
`define ARF_SIZE 32

// physical register pool, all start on the free list
`define PRF_SIZE 64

// renamed micro-ops buffered between rename and retire
`define DQ_DEPTH 8

`endif

//--- src/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    typedef logic [$clog2(`ARF_SIZE)-1:0] areg_id_t;
    typedef logic [$clog2(`PRF_SIZE)-1:0] preg_id_t;
    typedef logic [7:0]                   seq_t;     // wraps, program order only

    // major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        logic [6:0] funct7;
        areg_id_t   rs2;
        areg_id_t   rs1;
        logic [2:0] funct3;
        areg_id_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        areg_id_t    rs1;
        logic [2:0]  funct3;
        areg_id_t    rd;     // imm[4:0] for STORE/BRANCH
        logic [6:0]  opcode;
    } i_fmt_t;

    // same word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_u;

    typedef struct packed {
        seq_t     seq;
        areg_id_t rd;
        areg_id_t rs1;
        areg_id_t rs2;
        logic     rd_valid;
        logic     rs1_valid;
        logic     rs2_valid;
        preg_id_t prs1;
        logic     prs1_renamed;
        preg_id_t prs2;
        logic     prs2_renamed;
        preg_id_t prd;
        preg_id_t stale_preg;   // previous mapping of rd, freed at retire
        logic     stale_valid;
    } uop_t;

endpackage

//--- src/uop_if.sv
`timescale 1ns/100ps

// one micro-op link between pipeline stages
// a transfer happens on any edge with valid and ready both high
interface uop_if;

    logic             valid;   // from sender, held until taken
    logic             ready;   // from receiver
    rename_pkg::uop_t uop;     // stable while valid

    modport sender (
        output valid,
        output uop,
        input  ready
    );

    modport receiver (
        input  valid,
        input  uop,
        output ready
    );

endinterface

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   inst_req_i,
    output logic                   inst_ack_o,
    input  rename_pkg::inst_word_u inst_word_i,
    uop_if.sender                  uop_o
);

    import rename_pkg::*;

    logic       capture;
    logic [6:0] opcode;
    logic       has_rs1;
    logic       has_rs2;
    logic       has_rd;
    seq_t       seq_q;
    uop_t       dec_uop;

    assign opcode = inst_word_i.i.opcode;

    // register usage per opcode
    always_comb begin
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        has_rd  = 1'b0;
        case (opcode)
            OPC_OP: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                has_rd  = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                has_rs1 = 1'b1;
                has_rd  = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
            end
            default: ;   // no register use at all
        endcase
    end

    always_comb begin
        dec_uop           = '0;
        dec_uop.seq       = seq_q;
        dec_uop.rs1_valid = has_rs1;
        dec_uop.rs2_valid = has_rs2;
        dec_uop.rd_valid  = has_rd && (inst_word_i.i.rd != '0);   // x0 is never renamed
        dec_uop.rs1       = has_rs1 ? inst_word_i.i.rs1 : '0;
        dec_uop.rs2       = has_rs2 ? inst_word_i.r.rs2 : '0;   // R view only here
        dec_uop.rd        = dec_uop.rd_valid ? inst_word_i.i.rd : '0;
    end

    // slot free when empty or drained this cycle
    assign capture = inst_req_i && !inst_ack_o && (!uop_o.valid || uop_o.ready);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst_ack_o  <= 1'b0;
            uop_o.valid <= 1'b0;
            seq_q       <= '0;
        end else begin
            if (capture) begin
                inst_ack_o <= 1'b1;
                seq_q      <= seq_q + 8'd1;
            end else if (!inst_req_i) begin
                inst_ack_o <= 1'b0;   // req seen low, close the handshake
            end

            if (capture)
                uop_o.valid <= 1'b1;
            else if (uop_o.ready)
                uop_o.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            uop_o.uop <= dec_uop;
    end

endmodule

//--- src/rename_map.sv
`timescale 1ns/100ps
`include "rename_macros.svh"

module rename_map (
    input  logic                 clk,
    input  logic                 rstn,
    uop_if.receiver              uop_i,
    uop_if.sender                uop_o,
    input  logic                 free_valid_i,
    input  rename_pkg::preg_id_t free_preg_i
);

    import rename_pkg::*;

    localparam int FL_CNT_W = $clog2(`PRF_SIZE) + 1;

    // map table
    preg_id_t               rmt [`ARF_SIZE];
    logic [`ARF_SIZE-1:0]   rmt_renamed;

    // free list
    preg_id_t               fl_mem [`PRF_SIZE];
    preg_id_t               fl_head;
    preg_id_t               fl_tail;
    logic [FL_CNT_W-1:0]    fl_count;
    logic                   fl_empty;

    logic                   xfer_in;
    logic                   alloc;
    preg_id_t               new_preg;
    uop_t                   ren_uop;

    assign fl_empty = (fl_count == '0);
    assign new_preg = fl_mem[fl_head];

    // output slot free, and a register on hand if one is needed
    assign uop_i.ready = (!uop_o.valid || uop_o.ready) && (!uop_i.uop.rd_valid || !fl_empty);

    assign xfer_in = uop_i.valid && uop_i.ready;
    assign alloc   = xfer_in && uop_i.uop.rd_valid;

    always_comb begin
        ren_uop = uop_i.uop;

        ren_uop.prs1_renamed = uop_i.uop.rs1_valid && rmt_renamed[uop_i.uop.rs1];
        ren_uop.prs1         = ren_uop.prs1_renamed ? rmt[uop_i.uop.rs1] : '0;
        ren_uop.prs2_renamed = uop_i.uop.rs2_valid && rmt_renamed[uop_i.uop.rs2];
        ren_uop.prs2         = ren_uop.prs2_renamed ? rmt[uop_i.uop.rs2] : '0;

        ren_uop.prd          = uop_i.uop.rd_valid ? new_preg : '0;
        // old mapping of rd goes back to the pool at retire
        ren_uop.stale_valid  = uop_i.uop.rd_valid && rmt_renamed[uop_i.uop.rd];
        ren_uop.stale_preg   = ren_uop.stale_valid ? rmt[uop_i.uop.rd] : '0;
    end

    // map write, same edge as the read above
    always_ff @(posedge clk) begin
        if (alloc)
            rmt[uop_i.uop.rd] <= new_preg;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rmt_renamed <= '0;
        end else if (alloc) begin
            rmt_renamed[uop_i.uop.rd] <= 1'b1;
        end
    end

    // free list FIFO, pop at head and append at tail
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `PRF_SIZE; i++) begin
                fl_mem[i] <= preg_id_t'(i);   // pool starts as 0..63 in order
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FL_CNT_W'(`PRF_SIZE);
        end else begin
            if (alloc)
                fl_head <= fl_head + 1'b1;   // wraps at PRF_SIZE
            if (free_valid_i) begin
                fl_mem[fl_tail] <= free_preg_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            case ({alloc, free_valid_i})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: ;   // both or neither
            endcase
        end
    end

    // output register toward the dispatch queue
    always_ff @(posedge clk) begin
        if (!rstn) begin
            uop_o.valid <= 1'b0;
        end else if (xfer_in) begin
            uop_o.valid <= 1'b1;
        end else if (uop_o.ready) begin
            uop_o.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_in)
            uop_o.uop <= ren_uop;
    end

endmodule

//--- src/dispatch_queue.sv
`timescale 1ns/100ps
`include "rename_macros.svh"

module dispatch_queue (
    input  logic    clk,
    input  logic    rstn,
    uop_if.receiver enq_i,
    uop_if.sender   deq_o
);

    import rename_pkg::*;

    localparam int PTR_W = $clog2(`DQ_DEPTH);

    uop_t             mem [`DQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_enq;
    logic             do_deq;

    assign full = (count == (PTR_W+1)'(`DQ_DEPTH));

    assign deq_o.valid = (count != '0);
    assign deq_o.uop   = mem[rd_ptr];   // head entry
    assign enq_i.ready = !full || deq_o.ready;   // full but draining still accepts

    assign do_enq = enq_i.valid && enq_i.ready;
    assign do_deq = deq_o.valid && deq_o.ready;

    always_ff @(posedge clk) begin
        if (do_enq)
            mem[wr_ptr] <= enq_i.uop;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_deq)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- src/retire_unit.sv
`timescale 1ns/100ps

module retire_unit (
    input  logic                 clk,
    input  logic                 rstn,
    uop_if.receiver              uop_i,
    output logic                 uop_req_o,
    input  logic                 uop_ack_i,
    output rename_pkg::uop_t     uop_o,
    output logic                 free_valid_o,
    output rename_pkg::preg_id_t free_preg_o
);

    import rename_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_LOW
    } state_t;

    state_t state;
    uop_t   hold_uop;   // stays put until the next take

    assign uop_i.ready = (state == ST_IDLE);
    assign uop_req_o   = (state == ST_REQ);
    assign uop_o       = hold_uop;
    assign free_preg_o = hold_uop.stale_preg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= ST_IDLE;
            free_valid_o <= 1'b0;
        end else begin
            free_valid_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (uop_i.valid)
                        state <= ST_REQ;
                end
                ST_REQ: begin
                    if (uop_ack_i) begin
                        state        <= ST_WAIT_LOW;
                        free_valid_o <= hold_uop.stale_valid;   // pulse as req drops
                    end
                end
                ST_WAIT_LOW: begin
                    if (!uop_ack_i)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (uop_i.valid && uop_i.ready)
            hold_uop <= uop_i.uop;
    end

endmodule

//--- src/rename_top.sv
`timescale 1ns/100ps

module rename_top (
    input  logic                 clk,
    input  logic                 rstn,
    // instruction intake, four-phase
    input  logic                 inst_req_i,
    output logic                 inst_ack_o,
    input  logic [31:0]          inst_word_i,
    // micro-op output, four-phase
    output logic                 uop_req_o,
    input  logic                 uop_ack_i,
    output rename_pkg::seq_t     uop_seq_o,
    output rename_pkg::areg_id_t uop_rd_o,
    output logic                 uop_rd_valid_o,
    output rename_pkg::preg_id_t uop_prd_o,
    output rename_pkg::preg_id_t uop_prs1_o,
    output logic                 uop_prs1_renamed_o,
    output rename_pkg::preg_id_t uop_prs2_o,
    output logic                 uop_prs2_renamed_o
);

    import rename_pkg::*;

    uop_if dec_if ();   // decoder -> rename
    uop_if ren_if ();   // rename -> queue
    uop_if dq_if ();    // queue -> retire

    uop_t     ret_uop;
    logic     free_valid;
    preg_id_t free_preg;

    inst_decoder u_inst_decoder (
        .clk         (clk),
        .rstn        (rstn),
        .inst_req_i  (inst_req_i),
        .inst_ack_o  (inst_ack_o),
        .inst_word_i (inst_word_i),
        .uop_o       (dec_if.sender)
    );

    rename_map u_rename_map (
        .clk          (clk),
        .rstn         (rstn),
        .uop_i        (dec_if.receiver),
        .uop_o        (ren_if.sender),
        .free_valid_i (free_valid),
        .free_preg_i  (free_preg)
    );

    dispatch_queue u_dispatch_queue (
        .clk   (clk),
        .rstn  (rstn),
        .enq_i (ren_if.receiver),
        .deq_o (dq_if.sender)
    );

    retire_unit u_retire_unit (
        .clk          (clk),
        .rstn         (rstn),
        .uop_i        (dq_if.receiver),
        .uop_req_o    (uop_req_o),
        .uop_ack_i    (uop_ack_i),
        .uop_o        (ret_uop),
        .free_valid_o (free_valid),
        .free_preg_o  (free_preg)
    );

    // flatten the held micro-op
    assign uop_seq_o          = ret_uop.seq;
    assign uop_rd_o           = ret_uop.rd;
    assign uop_rd_valid_o     = ret_uop.rd_valid;
    assign uop_prd_o          = ret_uop.prd;
    assign uop_prs1_o         = ret_uop.prs1;
    assign uop_prs1_renamed_o = ret_uop.prs1_renamed;
    assign uop_prs2_o         = ret_uop.prs2;
    assign uop_prs2_renamed_o = ret_uop.prs2_renamed;

endmodule

//--- dv/tb_rename_top.sv
`timescale 1ns/100ps
`include "rename_macros.svh"

module tb_rename_top;

    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] LUI    = 7'b0110111;   // not handled, no register use
    // about 350 instructions at 80 cycles worst case, rounded up
    localparam int TIMEOUT_CYCLES = 30000;

    typedef struct packed {
        logic [7:0] seq;
        logic       rd_valid;
        logic [4:0] rd;
        logic [5:0] prd;
        logic [5:0] prs1;
        logic       prs1_ren;
        logic [5:0] prs2;
        logic       prs2_ren;
        logic [5:0] stale;
        logic       stale_valid;
    } exp_t;

    logic        clk;
    logic        rstn;
    logic        inst_req;
    logic        inst_ack;
    logic [31:0] inst_word;
    logic        uop_req;
    logic        uop_ack;
    logic [7:0]  uop_seq;
    logic [4:0]  uop_rd;
    logic        uop_rd_valid;
    logic [5:0]  uop_prd;
    logic [5:0]  uop_prs1;
    logic        uop_prs1_renamed;
    logic [5:0]  uop_prs2;
    logic        uop_prs2_renamed;

    // reference model state
    logic [5:0] ref_map [`ARF_SIZE];
    logic       ref_ren [`ARF_SIZE];
    logic [5:0] ref_free [$];
    logic [7:0] ref_seq;
    exp_t       exp_q [$];

    int         errors = 0;
    int         timeouts = 0;
    int         cycles = 0;
    int         accepted = 0;
    logic [5:0] last_prd;

    rename_top u_rename_top (
        .clk                (clk),
        .rstn               (rstn),
        .inst_req_i         (inst_req),
        .inst_ack_o         (inst_ack),
        .inst_word_i        (inst_word),
        .uop_req_o          (uop_req),
        .uop_ack_i          (uop_ack),
        .uop_seq_o          (uop_seq),
        .uop_rd_o           (uop_rd),
        .uop_rd_valid_o     (uop_rd_valid),
        .uop_prd_o          (uop_prd),
        .uop_prs1_o         (uop_prs1),
        .uop_prs1_renamed_o (uop_prs1_renamed),
        .uop_prs2_o         (uop_prs2),
        .uop_prs2_renamed_o (uop_prs2_renamed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            timeouts++;
            $display("timeout: run still going after %0d cycles", cycles);
            print_summary();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                          logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] rand_word();
        logic [6:0] opc;
        case ($urandom_range(0, 5))
            0:       opc = OP;
            1:       opc = OP_IMM;
            2:       opc = LOAD;
            3:       opc = STORE;
            4:       opc = BRANCH;
            default: opc = LUI;
        endcase
        // few registers so dependencies show up often
        return {7'($urandom), 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                3'($urandom), 5'($urandom_range(0, 7)), opc};
    endfunction

    task automatic print_summary();
        $display("summary: %0d errors, %0d timeouts", errors, timeouts);
    endtask

    task automatic check_field(input string name, input int got, input int exp_v);
        assert (got == exp_v) else begin
            errors++;
            $display("[FAIL] %0d ns: %s got %0d expected %0d", $time, name, got, exp_v);
        end
    endtask

    // decode and rename by the reference rules, in send order
    task automatic predict(input logic [31:0] w);
        logic [6:0] opc;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       use1;
        logic       use2;
        logic       wr;
        exp_t       e;
        opc  = w[6:0];
        rd   = w[11:7];
        rs1  = w[19:15];
        rs2  = w[24:20];
        use1 = (opc inside {OP, OP_IMM, LOAD, STORE, BRANCH});
        use2 = (opc inside {OP, STORE, BRANCH});
        wr   = (opc inside {OP, OP_IMM, LOAD}) && (rd != 5'd0);
        e = '0;
        e.seq = ref_seq;
        ref_seq = ref_seq + 8'd1;
        e.prs1_ren = use1 && ref_ren[rs1];
        if (e.prs1_ren) e.prs1 = ref_map[rs1];
        e.prs2_ren = use2 && ref_ren[rs2];
        if (e.prs2_ren) e.prs2 = ref_map[rs2];
        if (wr) begin
            e.rd_valid    = 1'b1;
            e.rd          = rd;
            e.prd         = ref_free.pop_front();
            e.stale_valid = ref_ren[rd];
            if (e.stale_valid) e.stale = ref_map[rd];
            ref_map[rd] = e.prd;
            ref_ren[rd] = 1'b1;
        end
        exp_q.push_back(e);
    endtask

    task automatic send_inst(input logic [31:0] w);
        predict(w);
        @(negedge clk);
        inst_word = w;
        inst_req  = 1'b1;
        while (!inst_ack) @(negedge clk);
        accepted++;
        inst_req = 1'b0;
        while (inst_ack) @(negedge clk);
    endtask

    task automatic recv_uop(input int delay);
        exp_t e;
        @(negedge clk);
        while (!uop_req) @(negedge clk);
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("micro-op with seq %0d arrived but none was expected", uop_seq);
        end
        e = exp_q.pop_front();
        check_field("seq", uop_seq, e.seq);
        check_field("rd_valid", uop_rd_valid, e.rd_valid);
        check_field("rd", uop_rd, e.rd);
        check_field("prd", uop_prd, e.prd);
        check_field("prs1", uop_prs1, e.prs1);
        check_field("prs1_renamed", uop_prs1_renamed, e.prs1_ren);
        check_field("prs2", uop_prs2, e.prs2);
        check_field("prs2_renamed", uop_prs2_renamed, e.prs2_ren);
        last_prd = uop_prd;
        repeat (delay) @(negedge clk);
        uop_ack = 1'b1;
        while (uop_req) @(negedge clk);
        uop_ack = 1'b0;
        if (e.stale_valid)
            ref_free.push_back(e.stale);   // old mapping back on the pool
    endtask

    task automatic run_one(input logic [31:0] w, input int delay);
        send_inst(w);
        recv_uop(delay);
    endtask

    task automatic test_reset_state();
        run_one(enc_r(OP, 5'd1, 5'd2, 5'd3), 0);
        check_field("first prd", last_prd, 0);
        run_one(enc_i(OP_IMM, 5'd2, 5'd4, 12'd5), 1);
        check_field("second prd", last_prd, 1);
        run_one(enc_i(LOAD, 5'd3, 5'd5, 12'd8), 2);
        check_field("third prd", last_prd, 2);
    endtask

    task automatic test_dep_chain();
        run_one(enc_i(OP_IMM, 5'd4, 5'd1, 12'd1), 0);
        run_one(enc_r(OP, 5'd5, 5'd4, 5'd2), 0);
        run_one(enc_r(OP, 5'd4, 5'd5, 5'd4), 1);
        run_one(enc_i(OP_IMM, 5'd6, 5'd4, 12'd3), 0);
        run_one(enc_r(OP, 5'd7, 5'd6, 5'd5), 2);
        run_one(enc_r(OP, 5'd7, 5'd7, 5'd7), 0);   // rd equal to both sources
    endtask

    task automatic test_no_dest();
        run_one(enc_r(STORE, 5'd4, 5'd7, 5'd6), 0);
        run_one(enc_r(BRANCH, 5'd8, 5'd6, 5'd7), 1);
        run_one(enc_r(OP, 5'd0, 5'd6, 5'd7), 0);
        run_one(enc_i(OP_IMM, 5'd0, 5'd0, 12'd0), 0);
        run_one(enc_i(LUI, 5'd8, 5'd3, 12'h123), 0);
        run_one(enc_i(OP_IMM, 5'd8, 5'd7, 12'd2), 0);
    endtask

    task automatic test_backpressure();
        int offered;
        int base;
        offered = `DQ_DEPTH + 6;
        base    = accepted;
        fork
            begin
                for (int i = 0; i < offered; i++)
                    send_inst(enc_r(OP, 5'(1 + i % 5), 5'(1 + (i + 1) % 5), 5'(2 + i % 3)));
            end
            begin
                repeat (offered * 10) @(negedge clk);
                // retire slot, queue, rename register and decoder slot all full
                check_field("instructions taken while output held", accepted - base,
                            `DQ_DEPTH + 3);
                assert (inst_req && !inst_ack) else begin
                    errors++;
                    $display("intake did not stall while the output ack was held back");
                end
                repeat (offered) recv_uop(0);
            end
        join
    endtask

    task automatic test_recycling();
        for (int i = 0; i < 72; i++)
            run_one(enc_i(OP_IMM, 5'(1 + i % 3), 5'(1 + (i + 1) % 3), 12'(i)), 0);
    endtask

    task automatic test_random_mix();
        fork
            begin
                for (int i = 0; i < 200; i++)
                    send_inst(rand_word());
            end
            begin
                for (int i = 0; i < 200; i++)
                    recv_uop(int'($urandom_range(0, 6)));
            end
        join
    endtask

    initial begin
        void'($urandom(32'hc387));   // one seed for the whole run
        rstn      = 1'b0;
        inst_req  = 1'b0;
        inst_word = '0;
        uop_ack   = 1'b0;
        ref_seq   = '0;
        for (int i = 0; i < `ARF_SIZE; i++) begin
            ref_map[i] = '0;
            ref_ren[i] = 1'b0;
        end
        for (int i = 0; i < `PRF_SIZE; i++)
            ref_free.push_back(6'(i));
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        test_reset_state();
        test_dep_chain();
        test_no_dest();
        test_backpressure();
        test_recycling();
        test_random_mix();

        repeat (4) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected micro-ops never came out", exp_q.size());
        end
        print_summary();
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
src/rename_pkg.sv
src/uop_if.sv
src/inst_decoder.sv
src/rename_map.sv
src/dispatch_queue.sv
src/retire_unit.sv
src/rename_top.sv
dv/tb_rename_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rename_top
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
